//--- Makefile
SIM = obj_dir/Vtb_corr_ctrl

.PHONY: all run lint clean

all: run

$(SIM): tb.f design/*.sv dv/*.sv
	verilator --binary --timing -Wno-fatal --top-module tb_corr_ctrl \
		-f tb.f -o Vtb_corr_ctrl

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing --top-module tb_corr_ctrl -f tb.f
	verilator --lint-only --top-module corr_ctrl_top \
		design/corr_pkg.sv design/cfg_wr_if.sv design/cmd_decoder.sv \
		design/line_cfg_regs.sv design/lag_scan_timer.sv design/corr_ctrl_top.sv

clean:
	rm -rf obj_dir sim.log

//--- design/cfg_wr_if.sv
// One configuration write from the command decoder to the line register file
// op is valid for a single cycle and there is no handshake
// bank follows the decoder's extended mode and is valid at all times
interface cfg_wr_if import corr_pkg::*; ();

	cfg_op_t    op;
	line_t      line;
	logic [1:0] sel;    // Voltage slice or digit index
	logic       bank;   // Extended mode selects the auto set
	nibble_t    data;

	modport src (
		output op,
		output line,
		output sel,
		output bank,
		output data
	);

	modport dst (
		input op,
		input line,
		input sel,
		input bank,
		input data
	);

endinterface

//--- design/cmd_decoder.sv
// Decodes the byte-wide command stream into configuration writes and flags
// One byte is taken on every edge with cmd_valid high and there is no back-pressure
// Opcode sits in bits 3:0 and the argument in bits 7:4
// Line select, baud rate and capture flags change on the command edge
// Register writes leave one cycle later on wr
// Unknown opcodes are dropped without any effect
module cmd_decoder import corr_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  byte_t   cmd,
	input  logic    cmd_valid,
	cfg_wr_if.src   wr,
	output line_t   current_line,
	output nibble_t baud_rate,
	output logic    integrating,
	output logic    external_clock,
	output logic    timestamp_reset
);

	dec_state_t state;
	cfg_op_t    op_nxt;
	nibble_t    arg;
	logic       is_digit;

	assign arg = cmd[7:4];
	assign is_digit = ({cmd[3:2], 2'b00} == OP_SET_DIGIT);   // Opcodes 8 to 11

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mode, line select and global flags

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= DEC_NORMAL;
			current_line <= '0;
			baud_rate <= '0;
			integrating <= 1'b0;
			external_clock <= 1'b0;
			timestamp_reset <= 1'b1;   // Timestamp held in reset until released
		end else if (cmd_valid) begin
			case (cmd[3:0])
			OP_SET_LINE: current_line <= cmd[5:4];
			OP_SET_BAUD: baud_rate <= arg;
			OP_CAPTURE: begin
				integrating <= cmd[4];
				external_clock <= cmd[5];
				timestamp_reset <= cmd[6];
				state <= cmd[7] ? DEC_EXTENDED : DEC_NORMAL;
			end
			default: ;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Configuration writes

	always_comb begin
		op_nxt = CFG_NONE;
		if (cmd_valid) begin
			if (is_digit) begin
				op_nxt = CFG_SET_DIGIT;
			end else begin
				case (cmd[3:0])
				OP_CLEAR:    op_nxt = CFG_CLEAR_START;
				OP_SET_VOLT: op_nxt = CFG_SET_VOLT;
				OP_TEST:     op_nxt = CFG_SET_TEST;
				default:     op_nxt = CFG_NONE;
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wr.op <= CFG_NONE;
		else
			wr.op <= op_nxt;
	end

	always_ff @(posedge clk) begin
		if (op_nxt != CFG_NONE) begin
			wr.line <= current_line;
			wr.sel <= is_digit ? cmd[1:0] : cmd[7:6];   // Digit index or voltage slice
			wr.data <= arg;
		end
	end

	// Mode only changes on capture commands, never together with a write
	assign wr.bank = (state == DEC_EXTENDED);

endmodule

//--- design/corr_ctrl_top.sv
// Control front end of the multi-line correlator
// Commands arrive as bytes with a valid strobe and have no ready signal
// APB is read-only and writes complete with pslverr
// ext_tick paces the lag scan only while external clock mode is set
module corr_ctrl_top import corr_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  byte_t     cmd,
	input  logic      cmd_valid,
	input  logic      ext_tick,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	output param_t    prdata,
	output logic      pready,
	output logic      pslverr,
	output param_t    lag,
	output logic      lag_valid,
	output logic      scan_done
);

	cfg_wr_if wr_bus ();

	line_t   current_line;
	nibble_t baud_rate;
	nibble_t flags;
	logic    integrating;
	logic    external_clock;
	logic    timestamp_reset;
	param_t  cur_start;
	param_t  cur_incr;
	param_t  cur_len;

	// Same bit order as the capture command's argument
	assign flags = {wr_bus.bank, timestamp_reset, external_clock, integrating};

	cmd_decoder u_dec (
		.clk             (clk),
		.rst_n           (rst_n),
		.cmd             (cmd),
		.cmd_valid       (cmd_valid),
		.wr              (wr_bus.src),
		.current_line    (current_line),
		.baud_rate       (baud_rate),
		.integrating     (integrating),
		.external_clock  (external_clock),
		.timestamp_reset (timestamp_reset)
	);

	line_cfg_regs u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.wr           (wr_bus.dst),
		.current_line (current_line),
		.cur_start    (cur_start),
		.cur_incr     (cur_incr),
		.cur_len      (cur_len),
		.flags        (flags),
		.baud_rate    (baud_rate),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

	lag_scan_timer u_timer (
		.clk            (clk),
		.rst_n          (rst_n),
		.integrating    (integrating),
		.external_clock (external_clock),
		.ext_tick       (ext_tick),
		.start          (cur_start),
		.incr           (cur_incr),
		.len            (cur_len),
		.lag            (lag),
		.lag_valid      (lag_valid),
		.scan_done      (scan_done)
	);

endmodule

//--- design/corr_pkg.sv
// Definitions shared by the correlator control front end and its testbench
// The line count is fixed at 4 to match the 2-bit line field of the APB address
// Scan parameters are 24 bits and are written by commands in 3-bit digits
package corr_pkg;

	localparam int NUM_LINES = 4;
	localparam int LINE_W = 2;
	localparam int PARAM_W = 24;
	localparam int HALF_W = PARAM_W / 2;   // One command-addressable half
	localparam int DIGIT_W = 3;

	typedef logic [LINE_W-1:0] line_t;
	typedef logic [PARAM_W-1:0] param_t;
	typedef logic [7:0] byte_t;
	typedef logic [3:0] nibble_t;
	typedef logic [7:0] apb_addr_t;       // [7:6] line, [3:0] register

	typedef enum logic [2:0] {
		CFG_NONE,
		CFG_CLEAR_START,
		CFG_SET_VOLT,
		CFG_SET_TEST,
		CFG_SET_DIGIT
	} cfg_op_t;

	typedef enum logic {
		DEC_NORMAL,
		DEC_EXTENDED
	} dec_state_t;

	// Low nibble of a command byte
	typedef enum logic [3:0] {
		OP_CLEAR     = 4'd0,
		OP_SET_LINE  = 4'd1,
		OP_SET_BAUD  = 4'd3,
		OP_SET_VOLT  = 4'd4,
		OP_SET_DIGIT = 4'd8,   // 8 to 11, digit index in bits 1:0
		OP_TEST      = 4'd12,
		OP_CAPTURE   = 4'd13
	} opcode_t;

	// Reset values of the scan parameters
	localparam param_t START_INIT = param_t'(0);
	localparam param_t INCR_INIT = param_t'(1);
	localparam param_t CROSS_LEN_INIT = param_t'(1023);
	localparam param_t AUTO_LEN_INIT = param_t'(1);

	// APB register map, low nibble of paddr
	localparam nibble_t REG_CROSS_START = 4'd0;
	localparam nibble_t REG_CROSS_INCR = 4'd1;
	localparam nibble_t REG_CROSS_LEN = 4'd2;
	localparam nibble_t REG_AUTO_START = 4'd3;
	localparam nibble_t REG_AUTO_INCR = 4'd4;
	localparam nibble_t REG_AUTO_LEN = 4'd5;
	localparam nibble_t REG_VOLT_TEST = 4'd6;
	localparam nibble_t REG_FLAGS_BAUD = 4'd7;

endpackage

//--- design/lag_scan_timer.sv
// Steps the cross lag of the selected line while integration runs
// Start, increment and length are sampled live from the current line
// A line change during a scan takes effect on the following step
// A length of zero runs as a one-step scan
module lag_scan_timer import corr_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   integrating,
	input  logic   external_clock,
	input  logic   ext_tick,
	input  param_t start,
	input  param_t incr,
	input  param_t len,
	output param_t lag,
	output logic   lag_valid,
	output logic   scan_done
);

	logic   integ_q;
	logic   load;
	logic   step;
	logic   advance;
	logic   last_step;
	param_t last_idx;
	param_t step_cnt;
	param_t acc;

	assign load = integrating && !integ_q;                // Rising edge of integrating
	assign step = external_clock ? ext_tick : 1'b1;
	assign advance = integrating && integ_q && step;
	assign last_idx = (len == '0) ? '0 : len - param_t'(1);
	assign last_step = (step_cnt == last_idx);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			integ_q <= 1'b0;
			step_cnt <= '0;
			lag_valid <= 1'b0;
			scan_done <= 1'b0;
		end else begin
			integ_q <= integrating;
			lag_valid <= advance;
			scan_done <= advance && last_step;
			if (load)
				step_cnt <= '0;
			else if (advance)
				step_cnt <= last_step ? '0 : step_cnt + param_t'(1);
		end
	end

	// Lag accumulator, wraps back to start after the last step
	always_ff @(posedge clk) begin
		if (load) begin
			acc <= start;
		end else if (advance) begin
			lag <= acc;
			acc <= last_step ? start : acc + incr;
		end
	end

endmodule

//--- design/line_cfg_regs.sv
// Per-line configuration storage with read-only APB access
// Scan parameters are written as 3-bit digits into 12-bit halves
// The target half comes from bits 6:4 of the line's test byte
// Field selects 6 and 7 leave digit writes without effect
// Every APB transfer takes one wait state and writes end with pslverr
// Unmapped register offsets read as zero
module line_cfg_regs import corr_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	cfg_wr_if.dst     wr,
	input  line_t     current_line,
	output param_t    cur_start,
	output param_t    cur_incr,
	output param_t    cur_len,
	input  nibble_t   flags,
	input  nibble_t   baud_rate,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	output param_t    prdata,
	output logic      pready,
	output logic      pslverr
);

	param_t cross_start [NUM_LINES];
	param_t cross_incr [NUM_LINES];
	param_t cross_len [NUM_LINES];
	param_t auto_start [NUM_LINES];
	param_t auto_incr [NUM_LINES];
	param_t auto_len [NUM_LINES];
	byte_t  volt [NUM_LINES];
	byte_t  test [NUM_LINES];

	logic [2:0]         field;
	logic [4:0]         dig_off;
	logic [DIGIT_W-1:0] dig_val;
	line_t              rd_line;
	nibble_t            rd_reg;
	param_t             rd_data;
	logic               acc_first;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command writes

	assign field = test[wr.line][6:4];
	assign dig_off = (field[0] ? 5'(HALF_W) : 5'd0) + 5'(wr.sel * DIGIT_W);
	assign dig_val = wr.data[DIGIT_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				cross_start[i] <= START_INIT;
				cross_incr[i] <= INCR_INIT;
				cross_len[i] <= CROSS_LEN_INIT;
				auto_start[i] <= START_INIT;
				auto_incr[i] <= INCR_INIT;
				auto_len[i] <= AUTO_LEN_INIT;
				volt[i] <= '0;
				test[i] <= '0;
			end
		end else begin
			case (wr.op)
			CFG_CLEAR_START: begin
				cross_start[wr.line][HALF_W-1:0] <= '0;
				auto_start[wr.line][HALF_W-1:0] <= '0;
			end
			CFG_SET_VOLT: volt[wr.line][{wr.sel, 1'b0} +: 2] <= wr.data[1:0];
			CFG_SET_TEST: test[wr.line][{wr.bank, 2'b00} +: 4] <= wr.data;
			CFG_SET_DIGIT: begin
				case (field[2:1])
				2'd0: begin
					if (wr.bank)
						auto_incr[wr.line][dig_off +: DIGIT_W] <= dig_val;
					else
						cross_incr[wr.line][dig_off +: DIGIT_W] <= dig_val;
				end
				2'd1: begin
					if (wr.bank)
						auto_len[wr.line][dig_off +: DIGIT_W] <= dig_val;
					else
						cross_len[wr.line][dig_off +: DIGIT_W] <= dig_val;
				end
				2'd2: begin
					if (wr.bank)
						auto_start[wr.line][dig_off +: DIGIT_W] <= dig_val;
					else
						cross_start[wr.line][dig_off +: DIGIT_W] <= dig_val;
				end
				default: ;
				endcase
			end
			default: ;
			endcase
		end
	end

	assign cur_start = cross_start[current_line];
	assign cur_incr = cross_incr[current_line];
	assign cur_len = cross_len[current_line];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB readback

	assign rd_line = paddr[7:6];
	assign rd_reg = paddr[3:0];
	assign acc_first = psel && penable && !pready;   // First access cycle

	always_comb begin
		case (rd_reg)
		REG_CROSS_START: rd_data = cross_start[rd_line];
		REG_CROSS_INCR:  rd_data = cross_incr[rd_line];
		REG_CROSS_LEN:   rd_data = cross_len[rd_line];
		REG_AUTO_START:  rd_data = auto_start[rd_line];
		REG_AUTO_INCR:   rd_data = auto_incr[rd_line];
		REG_AUTO_LEN:    rd_data = auto_len[rd_line];
		REG_VOLT_TEST:   rd_data = {8'd0, test[rd_line], volt[rd_line]};
		REG_FLAGS_BAUD:  rd_data = {16'd0, flags, baud_rate};
		default:         rd_data = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pready <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			pready <= acc_first;
			pslverr <= acc_first && pwrite;
		end
	end

	always_ff @(posedge clk) begin
		if (acc_first)
			prdata <= rd_data;
	end

endmodule

//--- dv/cmd_patterns.txt
# C cmd_byte | R apb_addr expected_data | W apb_addr | S lag_count
# All fields hex
R 00 000000
R 01 000001
R 02 0003ff
R 05 000001
R c2 0003ff
R 07 000040
W 41
R 41 000001
C 11
C 74
C 5c
C 93
R 46 00050c
R 07 000049
C 69
R 41 000031
C cd
R 07 0000c9
C 3c
C 5a
R 45 140001
C 4d
C 28
R 42 0023ff
C cd
C 4c
C 19
C 4d
R 43 000008
C 00
R 43 000000
R 46 00450c
C 21
C cd
C 2c
C 4d
C 38
C 09
C 0a
C 0b
R 82 000003
C 5d
S 07
C 7d
S 08
C 4d
R 07 000049

//--- dv/tb_corr_ctrl.sv
// Testbench for the correlator control front end
// Operations come from dv/cmd_patterns.txt, one per line, fields in hex
// A reference model recomputes every readback and every lag from the command rules
// Lag checks assume the current line's cross scan settings stay fixed while integrating
// ext_tick toggles randomly all the time and only matters in external clock mode
module tb_corr_ctrl import corr_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic      clk;
	logic      rst_n;
	byte_t     cmd;
	logic      cmd_valid;
	logic      ext_tick;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	param_t    prdata;
	logic      pready;
	logic      pslverr;
	param_t    lag;
	logic      lag_valid;
	logic      scan_done;

	// Reference model state
	param_t  m_cstart [NUM_LINES];
	param_t  m_cincr [NUM_LINES];
	param_t  m_clen [NUM_LINES];
	param_t  m_astart [NUM_LINES];
	param_t  m_aincr [NUM_LINES];
	param_t  m_alen [NUM_LINES];
	byte_t   m_volt [NUM_LINES];
	byte_t   m_test [NUM_LINES];
	line_t   m_line;
	nibble_t m_baud;
	logic    m_integ;
	logic    m_ext;
	logic    m_ts;
	logic    m_extm;

	int scan_idx;
	int edges_on;
	int lag_cnt;
	int ext_lag_cnt;
	int tick_cnt;
	int errors;
	int n_lines;
	int seed = 32'ha2e1;

	corr_ctrl_top dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.ext_tick  (ext_tick),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.lag       (lag),
		.lag_valid (lag_valid),
		.scan_done (scan_done)
	);

	always #20 clk = ~clk;

	always @(negedge clk) begin : tick_gen
		int rnd;
		rnd = $random(seed);
		ext_tick <= rnd[0];
	end

	task report_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		errors++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model

	task reset_model();
		for (int i = 0; i < NUM_LINES; i++) begin
			m_cstart[i] = 24'd0;
			m_astart[i] = 24'd0;
			m_cincr[i] = 24'd1;
			m_aincr[i] = 24'd1;
			m_clen[i] = 24'd1023;
			m_alen[i] = 24'd1;
			m_volt[i] = 8'd0;
			m_test[i] = 8'd0;
		end
		m_line = '0;
		m_baud = '0;
		{m_extm, m_ts, m_ext, m_integ} = 4'b0100;
	endtask

	function automatic param_t put_digit(param_t p, int pos, logic [2:0] v);
		p[pos +: 3] = v;
		return p;
	endfunction

	task apply_command(input byte_t b);
		logic [2:0] field;
		int pos;
		field = m_test[m_line][6:4];
		pos = (field[0] ? 12 : 0) + 3 * int'(b[1:0]);
		if (b[3:2] == 2'b10) begin
			case ({field[2:1], m_extm})
			3'b000: m_cincr[m_line] = put_digit(m_cincr[m_line], pos, b[6:4]);
			3'b001: m_aincr[m_line] = put_digit(m_aincr[m_line], pos, b[6:4]);
			3'b010: m_clen[m_line] = put_digit(m_clen[m_line], pos, b[6:4]);
			3'b011: m_alen[m_line] = put_digit(m_alen[m_line], pos, b[6:4]);
			3'b100: m_cstart[m_line] = put_digit(m_cstart[m_line], pos, b[6:4]);
			3'b101: m_astart[m_line] = put_digit(m_astart[m_line], pos, b[6:4]);
			default: ;
			endcase
		end else begin
			case (b[3:0])
			4'd0: begin
				m_cstart[m_line][11:0] = 12'd0;
				m_astart[m_line][11:0] = 12'd0;
			end
			4'd1: m_line = b[5:4];
			4'd3: m_baud = b[7:4];
			4'd4: m_volt[m_line][2 * int'(b[7:6]) +: 2] = b[5:4];
			4'd12: m_test[m_line][(m_extm ? 4 : 0) +: 4] = b[7:4];
			4'd13: begin
				if (b[4] && !m_integ) begin
					scan_idx = 0;
					edges_on = 0;
				end
				{m_extm, m_ts, m_ext, m_integ} = b[7:4];
			end
			default: ;
			endcase
		end
	endtask

	function automatic param_t model_read(apb_addr_t a);
		line_t l;
		l = a[7:6];
		case (a[3:0])
		4'd0: return m_cstart[l];
		4'd1: return m_cincr[l];
		4'd2: return m_clen[l];
		4'd3: return m_astart[l];
		4'd4: return m_aincr[l];
		4'd5: return m_alen[l];
		4'd6: return {8'd0, m_test[l], m_volt[l]};
		4'd7: return {16'd0, m_extm, m_ts, m_ext, m_integ, m_baud};
		default: return 24'd0;
		endcase
	endfunction

	// Lag monitor checks every cycle against the scan rules
	always @(posedge clk) begin : lag_monitor
		logic   exp_valid;
		param_t exp_lag;
		param_t n_len;
		#1;
		if (rst_n && m_integ) begin
			exp_valid = (edges_on >= 1) && (m_ext ? ext_tick : 1'b1);
			if (lag_valid !== exp_valid)
				report_mismatch($sformatf("lag_valid %b, expected %b", lag_valid, exp_valid));
			if (exp_valid && m_ext)
				tick_cnt++;
			edges_on++;
		end
		if (rst_n && lag_valid === 1'b1) begin
			n_len = (m_clen[m_line] == 24'd0) ? 24'd1 : m_clen[m_line];
			exp_lag = m_cstart[m_line] + param_t'(scan_idx) * m_cincr[m_line];
			if (lag !== exp_lag)
				report_mismatch($sformatf("lag %h, expected %h", lag, exp_lag));
			if (scan_done !== (param_t'(scan_idx) == n_len - 24'd1))
				report_mismatch($sformatf("scan_done %b at step %0d", scan_done, scan_idx));
			scan_idx = (param_t'(scan_idx) == n_len - 24'd1) ? 0 : scan_idx + 1;
			lag_cnt++;
			if (m_ext)
				ext_lag_cnt++;
		end else if (rst_n && scan_done !== 1'b0) begin
			report_mismatch($sformatf("scan_done %b without lag_valid", scan_done));
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus drivers

	task send_command(input byte_t b);
		@(negedge clk);
		cmd = b;
		cmd_valid = 1'b1;
		@(negedge clk);
		cmd_valid = 1'b0;
		apply_command(b);
	endtask

	task apb_access(input logic write, input apb_addr_t addr,
			output param_t data, output logic err);
		int waits;
		@(negedge clk);
		psel = 1'b1;
		pwrite = write;
		paddr = addr;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		waits = 0;
		do begin
			@(negedge clk);
			waits++;
		end while (pready !== 1'b1 && waits < 8);
		if (pready !== 1'b1) begin
			$display("APB transfer to %h never got pready", addr);
			errors++;
		end else if (waits != 1) begin
			report_mismatch($sformatf("pready in access cycle %0d, expected 2",
				waits + 1));
		end
		data = prdata;
		err = pslverr;
		@(negedge clk);   // Transfer completes on the edge with pready high
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task check_scan(input int count);
		int target;
		int cycles;
		target = lag_cnt + count;
		cycles = 0;
		while (lag_cnt < target && cycles < count * 32) begin
			@(negedge clk);
			cycles++;
		end
		if (lag_cnt < target) begin
			$display("scan produced %0d of %0d lags", count - (target - lag_cnt), count);
			errors++;
		end
		if (tick_cnt != ext_lag_cnt) begin
			$display("%0d external ticks but %0d lags", tick_cnt, ext_lag_cnt);
			errors++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence

	initial begin : watchdog
		wait (n_lines > 0);
		#(40 * 40 * n_lines);
		$display("timeout, the run did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : main
		int fd;
		int code;
		int n_pass;
		int n_fail;
		int err_before;
		int num;
		int line_total;
		string kind;
		string text;
		apb_addr_t addr;
		param_t value;
		param_t data;
		logic err;
		clk = 1'b0;
		rst_n = 1'b0;
		cmd = '0;
		cmd_valid = 1'b0;
		ext_tick = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		{errors, lag_cnt, ext_lag_cnt, tick_cnt, scan_idx, edges_on} = '0;
		{n_pass, n_fail, num} = '0;
		line_total = 0;
		reset_model();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		fd = $fopen("dv/cmd_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/cmd_patterns.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(text, fd);
				if (code > 0)
					line_total++;
			end
			$fclose(fd);
			n_lines = line_total;

			// Reset values of every line and register
			err_before = errors;
			for (int l = 0; l < NUM_LINES; l++) begin
				for (int r = 0; r < 8; r++) begin
					addr = {2'(l), 2'b00, 4'(r)};
					apb_access(1'b0, addr, data, err);
					if (data !== model_read(addr) || err !== 1'b0)
						report_mismatch($sformatf("reset read %h gave %h err %b, expected %h",
							addr, data, err, model_read(addr)));
				end
			end
			if (errors == err_before)
				n_pass++;
			else
				n_fail++;
			$display("test reset sweep %s", errors == err_before ? "ok" : "failed");

			fd = $fopen("dv/cmd_patterns.txt", "r");
			while ($fscanf(fd, "%s", kind) == 1) begin
				err_before = errors;
				if (kind == "#") begin
					code = $fgets(text, fd);
					continue;
				end
				num++;
				if (kind == "C") begin
					code = $fscanf(fd, "%h", value);
					send_command(value[7:0]);
				end else if (kind == "R") begin
					code = $fscanf(fd, "%h %h", addr, value);
					if (value !== model_read(addr)) begin
						$display("model and pattern file disagree at %h: %h vs %h",
							addr, model_read(addr), value);
						errors++;
					end
					apb_access(1'b0, addr, data, err);
					if (data !== value || err !== 1'b0)
						report_mismatch($sformatf("read %h gave %h err %b, expected %h",
							addr, data, err, value));
				end else if (kind == "W") begin
					code = $fscanf(fd, "%h", addr);
					apb_access(1'b1, addr, data, err);
					if (err !== 1'b1)
						report_mismatch($sformatf("write %h without pslverr", addr));
				end else if (kind == "S") begin
					code = $fscanf(fd, "%h", value);
					check_scan(int'(value));
				end else begin
					$display("unknown pattern kind %s", kind);
					errors++;
				end
				if (errors == err_before)
					n_pass++;
				else
					n_fail++;
				$display("test %0d (%s) %s", num, kind, errors == err_before ? "ok" : "failed");
			end
			$fclose(fd);
		end
		repeat (4) @(negedge clk);
		$display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
		if (n_fail == 0 && errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- tb.f
design/corr_pkg.sv
design/cfg_wr_if.sv
design/cmd_decoder.sv
design/line_cfg_regs.sv
design/lag_scan_timer.sv
design/corr_ctrl_top.sv
dv/tb_corr_ctrl.sv
